// File: list.f
src/rp_sample_pkg.sv
src/rp_bus_pkg.sv
src/rp_house_regs.sv
src/rp_adc_front.sv
src/rp_dac_back.sv
src/rp_pwm_dac.sv
src/rp_analog_top.sv
tb/rp_analog_properties.sv
tb/tb_analog_top.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_analog_top; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_analog_top +verilator+error+limit+1000 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qxF 'ALL CHECKS PASSED'; then
  exit 0
fi
echo "simulation did not pass"
exit 1

// File: src/rp_adc_front.sv
// ADC input stage, one register on the raw codes then negative slope conversion
// Loopback bypasses the register and shows the unregistered DAC sum

`timescale 1ns/1ps

module rp_adc_front (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,         // Sync, active low
  input  rp_sample_pkg::raw_pair_t adc_raw_i,       // Converter codes
  input  logic                     digital_loop_i,
  input  rp_sample_pkg::smp_pair_t dac_sum_i,       // Saturated DAC sum
  output rp_sample_pkg::smp_pair_t adc_dat_o        // To scope and PID
);

  rp_sample_pkg::raw_pair_t adc_raw_q;
  rp_sample_pkg::smp_pair_t adc_conv;               // Converter path after mapping

  ////////////////////////////////////////////////////////////////////////////
  // Input registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      adc_raw_q <= '0;
    else
      adc_raw_q <= adc_raw_i;
  end

  // Unsigned negative slope into two's complement
  always_comb
  begin
    adc_conv.a = rp_sample_pkg::raw_to_smp(adc_raw_q.a);
    adc_conv.b = rp_sample_pkg::raw_to_smp(adc_raw_q.b);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Loopback select
  ////////////////////////////////////////////////////////////////////////////

  // Both channels switch together
  assign adc_dat_o = digital_loop_i ? dac_sum_i : adc_conv;

endmodule

// File: src/rp_analog_top.sv
// Analog glue of the two-channel board, single adc_clk domain
// Scope, generator and controller live outside, their samples are ports here

`timescale 1ns/1ps

module rp_analog_top (
  input  logic                                adc_clk,
  input  logic                                rst_n_i,     // Sync, active low
  // System bus
  input  rp_bus_pkg::sys_req_t                sys_req_i,
  output rp_bus_pkg::sys_rsp_t                sys_rsp_o,
  // Converters and sample streams
  input  rp_sample_pkg::raw_pair_t            adc_raw_i,
  input  rp_sample_pkg::smp_pair_t            asg_dat_i,   // Generator
  input  rp_sample_pkg::smp_pair_t            pid_dat_i,   // Controller
  output rp_sample_pkg::smp_pair_t            adc_dat_o,   // For scope and PID
  output rp_sample_pkg::raw_pair_t            dac_raw_o,
  // Slow analog outputs
  output logic [rp_sample_pkg::PWM_N-1:0]     pwm_o
);

  logic                                            digital_loop;
  rp_sample_pkg::duty_t [rp_sample_pkg::PWM_N-1:0] duty;
  rp_sample_pkg::smp_pair_t                        dac_sum;   // Loopback source

  ////////////////////////////////////////////////////////////////////////////
  // Housekeeping registers
  ////////////////////////////////////////////////////////////////////////////

  rp_house_regs i_house_regs (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (rst_n_i     ),
    .sys_req_i      (sys_req_i   ),
    .sys_rsp_o      (sys_rsp_o   ),
    .digital_loop_o (digital_loop),
    .duty_o         (duty        )
  );

  ////////////////////////////////////////////////////////////////////////////
  // ADC and DAC datapath
  ////////////////////////////////////////////////////////////////////////////

  rp_adc_front i_adc_front (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (rst_n_i     ),
    .adc_raw_i      (adc_raw_i   ),
    .digital_loop_i (digital_loop),
    .dac_sum_i      (dac_sum     ),
    .adc_dat_o      (adc_dat_o   )
  );

  rp_dac_back i_dac_back (
    .adc_clk   (adc_clk  ),
    .rst_n_i   (rst_n_i  ),
    .asg_dat_i (asg_dat_i),
    .pid_dat_i (pid_dat_i),
    .dac_sum_o (dac_sum  ),
    .dac_raw_o (dac_raw_o)
  );

  // One PWM output per duty register
  for (genvar i = 0; i < rp_sample_pkg::PWM_N; i++)
  begin : g_pwm
    rp_pwm_dac i_pwm_dac (
      .adc_clk (adc_clk ),
      .rst_n_i (rst_n_i ),
      .duty_i  (duty[i] ),
      .pwm_o   (pwm_o[i])
    );
  end

endmodule

// File: src/rp_bus_pkg.sv
// System bus types and register map of the housekeeping block
// Plain one-cycle wen/ren strobes, ack one cycle later, no back-pressure

package rp_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int BUS_AW = 12;                       // Byte address
  localparam int BUS_DW = 32;

  // Master side request
  typedef struct packed {
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] wdata;
    logic              wen;                         // One-cycle write strobe
    logic              ren;                         // One-cycle read strobe
  } sys_req_t;

  // Slave side response, valid while ack is high
  typedef struct packed {
    logic [BUS_DW-1:0] rdata;
    logic              ack;
    logic              err;                         // Unmapped address
  } sys_rsp_t;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [BUS_AW-1:0] {
    REG_ID   = 12'h000,                             // Read only identification
    REG_CTRL = 12'h004,                             // Bit 0 digital loopback
    REG_PWM0 = 12'h020,                             // Bits 7:0 duty
    REG_PWM1 = 12'h024,
    REG_PWM2 = 12'h028,
    REG_PWM3 = 12'h02C
  } reg_addr_e;

  // Board and revision tag
  localparam logic [BUS_DW-1:0] ID_WORD = 32'h5250_0001;

endpackage

// File: src/rp_dac_back.sv
// DAC output stage, generator plus controller sample with saturation to 14 bits
// Both channels share adc_clk, outputs are two parallel converter buses

`timescale 1ns/1ps

module rp_dac_back (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,         // Sync, active low
  input  rp_sample_pkg::smp_pair_t asg_dat_i,       // Generator samples
  input  rp_sample_pkg::smp_pair_t pid_dat_i,       // Controller samples
  output rp_sample_pkg::smp_pair_t dac_sum_o,       // Unregistered, for loopback
  output rp_sample_pkg::raw_pair_t dac_raw_o        // Registered converter codes
);

  logic signed [rp_sample_pkg::SMP_W:0] sum_a;      // One guard bit
  logic signed [rp_sample_pkg::SMP_W:0] sum_b;

  // Clamp when the two top bits disagree
  function automatic rp_sample_pkg::smp_t sat(logic signed [rp_sample_pkg::SMP_W:0] s);
    logic sgn;
    sgn = s[rp_sample_pkg::SMP_W];
    if (sgn ^ s[rp_sample_pkg::SMP_W-1])
      return {sgn, {(rp_sample_pkg::SMP_W-1){~sgn}}};  // +8191 or -8192
    else
      return s[rp_sample_pkg::SMP_W-1:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Sum and saturation
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    sum_a = asg_dat_i.a + pid_dat_i.a;              // Sign extended by context
    sum_b = asg_dat_i.b + pid_dat_i.b;
  end

  assign dac_sum_o.a = sat(sum_a);
  assign dac_sum_o.b = sat(sum_b);

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  // Back to unsigned negative slope code
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_raw_o.a <= rp_sample_pkg::RAW_ZERO;       // Mid scale after reset
      dac_raw_o.b <= rp_sample_pkg::RAW_ZERO;
    end
    else
    begin
      dac_raw_o.a <= rp_sample_pkg::smp_to_raw(dac_sum_o.a);
      dac_raw_o.b <= rp_sample_pkg::smp_to_raw(dac_sum_o.b);
    end
  end

endmodule

// File: src/rp_house_regs.sv
// Register bank on the system bus, one access per two cycles at most
// Writes to REG_ID are acked and dropped, unused bits read as zero

`timescale 1ns/1ps

module rp_house_regs (
  input  logic                                            adc_clk,
  input  logic                                            rst_n_i,        // Sync, active low
  input  rp_bus_pkg::sys_req_t                            sys_req_i,
  output rp_bus_pkg::sys_rsp_t                            sys_rsp_o,
  output logic                                            digital_loop_o, // ADC shows DAC sum
  output rp_sample_pkg::duty_t [rp_sample_pkg::PWM_N-1:0] duty_o
);

  logic                                 ctrl_sel;   // REG_CTRL addressed
  logic [rp_sample_pkg::PWM_N-1:0]      pwm_sel;    // One-hot duty register select
  logic                                 addr_hit;   // Address is in the map
  logic [rp_bus_pkg::BUS_DW-1:0]        rd_val;     // Read mux output

  logic                                 ack_q;
  logic                                 err_q;
  logic [rp_bus_pkg::BUS_DW-1:0]        rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode and read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    ctrl_sel = 1'b0;
    pwm_sel  = '0;
    addr_hit = 1'b1;
    rd_val   = '0;
    case (sys_req_i.addr)
      rp_bus_pkg::REG_ID   : rd_val = rp_bus_pkg::ID_WORD;
      rp_bus_pkg::REG_CTRL :
      begin
        ctrl_sel  = 1'b1;
        rd_val[0] = digital_loop_o;
      end
      rp_bus_pkg::REG_PWM0 : pwm_sel[0] = 1'b1;
      rp_bus_pkg::REG_PWM1 : pwm_sel[1] = 1'b1;
      rp_bus_pkg::REG_PWM2 : pwm_sel[2] = 1'b1;
      rp_bus_pkg::REG_PWM3 : pwm_sel[3] = 1'b1;
      default              : addr_hit = 1'b0;   // Outside the map
    endcase
    // Duty readback, upper bits stay zero
    for (int i = 0; i < rp_sample_pkg::PWM_N; i++)
    begin
      if (pwm_sel[i])
        rd_val[rp_sample_pkg::PWM_W-1:0] = duty_o[i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      duty_o         <= '0;                         // All PWM outputs low
    end
    else if (sys_req_i.wen)
    begin
      if (ctrl_sel)
        digital_loop_o <= sys_req_i.wdata[0];
      for (int i = 0; i < rp_sample_pkg::PWM_N; i++)
      begin
        if (pwm_sel[i])
          duty_o[i] <= sys_req_i.wdata[rp_sample_pkg::PWM_W-1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response, one cycle after the strobe
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end
    else
    begin
      ack_q <= sys_req_i.wen | sys_req_i.ren;
      err_q <= (sys_req_i.wen | sys_req_i.ren) & ~addr_hit;
    end
  end

  // Read data captured on the read strobe only
  always_ff @(posedge adc_clk)
  begin
    if (sys_req_i.ren)
      rdata_q <= rd_val;
  end

  assign sys_rsp_o = '{rdata: rdata_q, ack: ack_q, err: err_q};

endmodule

// File: src/rp_pwm_dac.sv
// Slow PWM analog output, 256 cycle period, duty high cycles per period
// Duty 0 keeps the output low, duty 255 leaves one low cycle

`timescale 1ns/1ps

module rp_pwm_dac (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,             // Sync, active low
  input  rp_sample_pkg::duty_t duty_i,              // From the register bank
  output logic                 pwm_o
);

  logic [rp_sample_pkg::PWM_W-1:0] cnt_q;            // Free-running period counter

  ////////////////////////////////////////////////////////////////////////////
  // Period counter and compare
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      cnt_q <= '0;
    else
      cnt_q <= cnt_q + 1'b1;                        // Wraps at 255
  end

  // Registered compare keeps the pin glitch free
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      pwm_o <= 1'b0;
    else
      pwm_o <= (cnt_q < duty_i);
  end

endmodule

// File: src/rp_sample_pkg.sv
// Sample and PWM definitions shared by the analog datapath
// Converter codes are unsigned with negative slope, samples are two's complement

package rp_sample_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sample widths and types
  ////////////////////////////////////////////////////////////////////////////

  localparam int SMP_W = 14;                        // ADC and DAC resolution

  typedef logic        [SMP_W-1:0] adc_raw_t;       // Converter code
  typedef logic signed [SMP_W-1:0] smp_t;           // Two's complement sample

  // Channel pairs, a in the upper half
  typedef struct packed {
    smp_t a;
    smp_t b;
  } smp_pair_t;

  typedef struct packed {
    adc_raw_t a;
    adc_raw_t b;
  } raw_pair_t;

  // Converter code of sample 0, mid scale
  localparam adc_raw_t RAW_ZERO = 14'h1FFF;

  // Negative slope mapping, top bit kept and the rest inverted
  function automatic smp_t raw_to_smp(adc_raw_t raw);
    return smp_t'({raw[SMP_W-1], ~raw[SMP_W-2:0]});
  endfunction

  function automatic adc_raw_t smp_to_raw(smp_t smp);
    return adc_raw_t'({smp[SMP_W-1], ~smp[SMP_W-2:0]});
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // PWM outputs
  ////////////////////////////////////////////////////////////////////////////

  localparam int PWM_N = 4;                         // Number of slow outputs
  localparam int PWM_W = 8;                         // Duty and counter width, 256 cycle period

  typedef logic [PWM_W-1:0] duty_t;

endpackage

// File: tb/rp_analog_properties.sv
// Concurrent checks of the analog top, bound to every instance of it
// Expects inputs to settle away from the rising edge, checks idle during reset

`timescale 1ns/1ps

module rp_analog_properties (
  input logic                     adc_clk,
  input logic                     rst_n_i,
  input rp_bus_pkg::sys_req_t     sys_req_i,
  input rp_bus_pkg::sys_rsp_t     sys_rsp_i,
  input rp_sample_pkg::raw_pair_t adc_raw_i,
  input rp_sample_pkg::smp_pair_t asg_dat_i,
  input rp_sample_pkg::smp_pair_t pid_dat_i,
  input rp_sample_pkg::smp_pair_t adc_dat_i,
  input rp_sample_pkg::raw_pair_t dac_raw_i,
  input logic                     digital_loop_i
);

  localparam int FULL_POS = 2**(rp_sample_pkg::SMP_W-1) - 1;   // +8191
  localparam int FULL_NEG = -(2**(rp_sample_pkg::SMP_W-1));    // -8192

  int                       assert_fails = 0;     // Polled by the testbench
  rp_sample_pkg::smp_pair_t sum_exp;              // Clamped sum, this cycle
  rp_sample_pkg::raw_pair_t code_exp;             // Its converter code
  rp_sample_pkg::smp_pair_t conv_exp;             // Raw input as a sample

  function automatic int clamp_sum(int x, int y);
    int s;
    s = x + y;
    if (s > FULL_POS)
      s = FULL_POS;
    else if (s < FULL_NEG)
      s = FULL_NEG;
    return s;
  endfunction

  // Negative slope with offset, code = 8191 - sample modulo 2^14
  always_comb
  begin
    sum_exp.a  = rp_sample_pkg::smp_t'(clamp_sum(asg_dat_i.a, pid_dat_i.a));
    sum_exp.b  = rp_sample_pkg::smp_t'(clamp_sum(asg_dat_i.b, pid_dat_i.b));
    code_exp.a = rp_sample_pkg::adc_raw_t'(FULL_POS - int'(sum_exp.a));
    code_exp.b = rp_sample_pkg::adc_raw_t'(FULL_POS - int'(sum_exp.b));
    conv_exp.a = rp_sample_pkg::smp_t'(FULL_POS - int'(adc_raw_i.a));
    conv_exp.b = rp_sample_pkg::smp_t'(FULL_POS - int'(adc_raw_i.b));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus and datapath properties
  ////////////////////////////////////////////////////////////////////////////

  // Ack one cycle after each strobe and never otherwise
  a_ack: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    $past(rst_n_i) |-> sys_rsp_i.ack == $past(sys_req_i.wen || sys_req_i.ren))
    else
    begin
      assert_fails++;
      $error("ack does not follow the strobe by exactly one cycle");
    end

  a_dac: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    $past(rst_n_i) |-> dac_raw_i == $past(code_exp))
    else
    begin
      assert_fails++;
      $error("dac_raw_o differs from the clamped sum of the previous cycle");
    end

  // Loopback is combinational, converter path has one register
  a_adc: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    $past(rst_n_i) |-> (digital_loop_i ? adc_dat_i == sum_exp
                                       : adc_dat_i == $past(conv_exp)))
    else
    begin
      assert_fails++;
      $error("adc_dat_o differs from the selected source");
    end

endmodule

bind rp_analog_top rp_analog_properties i_props (
  .adc_clk        (adc_clk     ),
  .rst_n_i        (rst_n_i     ),
  .sys_req_i      (sys_req_i   ),
  .sys_rsp_i      (sys_rsp_o   ),
  .adc_raw_i      (adc_raw_i   ),
  .asg_dat_i      (asg_dat_i   ),
  .pid_dat_i      (pid_dat_i   ),
  .adc_dat_i      (adc_dat_o   ),
  .dac_raw_i      (dac_raw_o   ),
  .digital_loop_i (digital_loop)
);

// File: tb/tb_analog_top.sv
// Fixed-seed random and directed stimulus while bound properties check the datapath
// Needs simulator timing support and keeps one bus access per two cycles

`timescale 1ns/1ps

module tb_analog_top;

  logic                            adc_clk;
  logic                            rst_n_i;
  rp_bus_pkg::sys_req_t            sys_req;
  rp_bus_pkg::sys_rsp_t            sys_rsp;
  rp_sample_pkg::raw_pair_t        adc_raw;
  rp_sample_pkg::smp_pair_t        asg_dat;
  rp_sample_pkg::smp_pair_t        pid_dat;
  rp_sample_pkg::smp_pair_t        adc_dat;
  rp_sample_pkg::raw_pair_t        dac_raw;
  logic [rp_sample_pkg::PWM_N-1:0] pwm;

  int          n_tests = 0;
  int          n_bad_tests = 0;
  int          n_errors = 0;                      // Value mismatches
  int          n_timeouts = 0;
  logic [31:0] rd;                                // Last read data
  logic        rd_err;                            // Last err flag
  int          hi_cnt [rp_sample_pkg::PWM_N];
  int          duties [4] = '{0, 1, 128, 255};

  initial
  begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;               // 40 ns period
  end

  rp_analog_top i_rp_analog_top (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .sys_req_i (sys_req),
    .sys_rsp_o (sys_rsp),
    .adc_raw_i (adc_raw),
    .asg_dat_i (asg_dat),
    .pid_dat_i (pid_dat),
    .adc_dat_o (adc_dat),
    .dac_raw_o (dac_raw),
    .pwm_o     (pwm    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge adc_clk);
    #2;                                           // Drive away from the edge
  endtask

  function automatic int total_errors();
    return n_errors + n_timeouts + i_rp_analog_top.i_props.assert_fails;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      n_errors++;
      $display("Error at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    n_tests++;
    if (total_errors() == errs_at_start)
      $display("test %s: ok", name);
    else
    begin
      n_bad_tests++;
      $display("test %s: failed", name);
    end
  endtask

  // One strobe and a bounded wait for ack before an idle cycle
  task automatic bus_access(input logic wr, input logic [11:0] adr, input logic [31:0] wdat);
    int wait_cnt;
    sys_req = '{addr: adr, wdata: wdat, wen: wr, ren: !wr};
    next_cycle();
    sys_req.wen = 1'b0;
    sys_req.ren = 1'b0;
    wait_cnt = 0;
    while (!sys_rsp.ack && wait_cnt < 8)
    begin
      next_cycle();
      wait_cnt++;
    end
    if (sys_rsp.ack)
    begin
      rd     = sys_rsp.rdata;
      rd_err = sys_rsp.err;
    end
    else
    begin
      n_timeouts++;
      $display("Timeout: no ack from the bus for address %h", adr);
    end
    next_cycle();
  endtask

  task automatic drive_random(input int cycles, input logic raw_en, input logic smp_en);
    logic [31:0] rnd;
    for (int i = 0; i < cycles; i++)
    begin
      rnd = $urandom;
      if (raw_en)
        adc_raw = rnd[27:0];
      rnd = $urandom;
      if (smp_en)
        asg_dat = rnd[27:0];
      rnd = $urandom;
      if (smp_en)
        pid_dat = rnd[27:0];
      next_cycle();
    end
  endtask

  // Channel b gets the operands swapped
  task automatic drive_sum(input int x, input int y);
    asg_dat = '{a: rp_sample_pkg::smp_t'(x), b: rp_sample_pkg::smp_t'(y)};
    pid_dat = '{a: rp_sample_pkg::smp_t'(y), b: rp_sample_pkg::smp_t'(x)};
    next_cycle();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int          mark;
    logic [31:0] rnd;
    void'($urandom(32'h982b_1722));
    rst_n_i = 1'b0;
    sys_req = '0;
    adc_raw = '0;
    asg_dat = '0;
    pid_dat = '0;
    rd      = '0;
    rd_err  = 1'b0;
    repeat (2) next_cycle();                      // Two edges in reset
    rst_n_i = 1'b1;

    mark = total_errors();
    check_val("pwm_o", 32'h0, pwm);
    check_val("sys_rsp_o.ack", 32'h0, sys_rsp.ack);
    check_val("sys_rsp_o.err", 32'h0, sys_rsp.err);
    check_val("dac_raw_o.a", 32'h1FFF, dac_raw.a);  // Code of sample 0
    check_val("dac_raw_o.b", 32'h1FFF, dac_raw.b);
    end_test("reset values", mark);

    mark = total_errors();
    bus_access(1'b0, 12'h000, '0);
    check_val("REG_ID", 32'h5250_0001, rd);
    check_val("sys_rsp_o.err", 32'h0, rd_err);
    bus_access(1'b1, 12'h000, 32'hDEAD_BEEF);     // Read only and dropped
    bus_access(1'b0, 12'h000, '0);
    check_val("REG_ID after write", 32'h5250_0001, rd);
    bus_access(1'b0, 12'h004, '0);                // Other registers keep reset values
    check_val("REG_CTRL after REG_ID write", 32'h0, rd);
    bus_access(1'b0, 12'h020, '0);
    check_val("REG_PWM0 after REG_ID write", 32'h0, rd);
    bus_access(1'b1, 12'h004, 32'hFFFF_FFFF);
    bus_access(1'b0, 12'h004, '0);
    check_val("REG_CTRL", 32'h1, rd);
    bus_access(1'b1, 12'h004, 32'hFFFF_FFFE);     // Loopback off again
    bus_access(1'b0, 12'h004, '0);
    check_val("REG_CTRL", 32'h0, rd);
    for (int i = 0; i < 4; i++)
    begin
      rnd = $urandom;
      bus_access(1'b1, 12'h020 + 12'(4 * i), rnd);
      bus_access(1'b0, 12'h020 + 12'(4 * i), '0);
      check_val($sformatf("REG_PWM%0d", i), rnd & 32'h0000_00FF, rd);
    end
    bus_access(1'b0, 12'h008, '0);                // Hole in the map
    check_val("sys_rsp_o.err", 32'h1, rd_err);
    bus_access(1'b1, 12'h100, '1);
    check_val("sys_rsp_o.err", 32'h1, rd_err);
    end_test("register access", mark);

    mark = total_errors();
    drive_random(200, 1'b1, 1'b0);
    end_test("adc conversion", mark);

    mark = total_errors();
    drive_random(200, 1'b0, 1'b1);
    drive_sum(8191, 8191);                        // Positive clamp
    drive_sum(-8192, -8192);                      // Negative clamp
    drive_sum(8191, -8192);
    drive_sum(-3000, 5000);
    drive_sum(8191, 1);
    drive_sum(-8192, -1);
    next_cycle();                                 // Last sum reaches the output
    end_test("dac sum and saturation", mark);

    mark = total_errors();
    bus_access(1'b1, 12'h004, 32'h1);
    drive_random(100, 1'b1, 1'b1);
    drive_sum(8191, 8191);
    bus_access(1'b1, 12'h004, 32'h0);
    drive_random(50, 1'b1, 1'b1);
    end_test("loopback", mark);

    // Duties rotate so every output sees every value
    mark = total_errors();
    for (int k = 0; k < 4; k++)
    begin
      for (int i = 0; i < 4; i++)
        bus_access(1'b1, 12'h020 + 12'(4 * i), duties[(k + i) % 4]);
      hi_cnt = '{default: 0};
      repeat (256)
      begin
        for (int i = 0; i < 4; i++)
          hi_cnt[i] += int'(pwm[i]);
        next_cycle();
      end
      for (int i = 0; i < 4; i++)
        check_val($sformatf("pwm_o[%0d] high cycles", i), duties[(k + i) % 4], hi_cnt[i]);
    end
    end_test("pwm duty", mark);

    $display("tests %0d, failed tests %0d, value errors %0d, timeouts %0d, assertion fails %0d",
             n_tests, n_bad_tests, n_errors, n_timeouts, i_rp_analog_top.i_props.assert_fails);
    if (n_bad_tests == 0 && total_errors() == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule
